// ==== hw/rvviPkg.sv ====
package rvviPkg;

   localparam int XLEN    = 32;
   localparam int NUM_GPR = 32;

   typedef logic [XLEN-1:0]    wordT;
   typedef logic [NUM_GPR-1:0] gprMaskT;

   //////////////////////////////
   // Cause codes
   //////////////////////////////

   // Instruction bus fault, raised outside the core
   localparam logic [5:0]  FETCH_FAULT_CAUSE = 6'd48;

   // Data bus fault NMIs
   localparam logic [10:0] NMI_LOAD_CAUSE    = 11'd1024;
   localparam logic [10:0] NMI_STORE_CAUSE   = 11'd1025;

   // External halt request
   localparam logic [2:0]  HALTREQ_DBG_CAUSE = 3'd3;

   // MSW, MTimer, MExternal and the sixteen local lines
   localparam logic [31:0] IRQ_USED_MASK     = 32'hFFFF_0888;

   //////////////////////////////
   // Net snapshot
   //////////////////////////////

   typedef struct packed {
      logic [31:0] irq;
      logic [10:0] nmiCause;
      logic        haltReq;
      logic        nmi;
      logic        fetchFault;
      logic [1:0]  spare;
   } netSnapT;

endpackage

// ==== hw/retireStage.sv ====
`timescale 1ns/1ps

module retireStage
   import rvviPkg::*;
(
   input  logic               rvvi,
   input  logic               arstN_i,
   input  logic               rvfiValid_i,
   input  logic [63:0]        rvfiOrder_i,
   input  wordT               rvfiInsn_i,
   input  logic               rvfiTrap_i,
   input  logic [5:0]         rvfiExcCause_i,
   input  logic               rvfiIntr_i,
   input  logic [1:0]         rvfiMode_i,
   input  logic [1:0]         rvfiIxl_i,
   input  wordT               rvfiPcRdata_i,
   input  wordT               rvfiPcWdata_i,
   input  gprMaskT            rvfiGprWmask_i,
   input  wordT [NUM_GPR-1:0] rvfiGprWdata_i,
   output logic               valid_o,
   output logic [63:0]        order_o,
   output wordT               insn_o,
   output logic               trap_o,
   output logic               intr_o,
   output logic [1:0]         mode_o,
   output logic [1:0]         ixl_o,
   output wordT               pcRdata_o,
   output wordT               pcWdata_o,
   output gprMaskT            xWb_o,
   output wordT [NUM_GPR-1:0] xWdata_o
);

   wordT [NUM_GPR-1:0] maskedGpr;

   // Registers not written this retirement read as zero
   always_comb begin
      for (int i = 0; i < NUM_GPR; i++) begin
         maskedGpr[i] = rvfiGprWmask_i[i] ? rvfiGprWdata_i[i] : '0;
      end
      // x0 is hardwired
      maskedGpr[0] = '0;
   end

   always_ff @(posedge rvvi or negedge arstN_i) begin
      if (!arstN_i) begin
         valid_o <= 1'b0;
         trap_o  <= 1'b0;
         intr_o  <= 1'b0;
         xWb_o   <= '0;
      end else begin
         valid_o <= rvfiValid_i;
         // Only the external fetch fault is reported as a trap
         trap_o  <= rvfiTrap_i && (rvfiExcCause_i == FETCH_FAULT_CAUSE);
         intr_o  <= rvfiIntr_i;
         xWb_o   <= rvfiGprWmask_i;
      end
   end

   always_ff @(posedge rvvi) begin
      order_o   <= rvfiOrder_i;
      insn_o    <= rvfiInsn_i;
      mode_o    <= rvfiMode_i;
      ixl_o     <= rvfiIxl_i;
      pcRdata_o <= rvfiPcRdata_i;
      pcWdata_o <= rvfiPcWdata_i;
      xWdata_o  <= maskedGpr;
   end

   // The core never reports a write to x0
   noX0Write: assert property (@(posedge rvvi) disable iff (!arstN_i)
      rvfiValid_i |-> !rvfiGprWmask_i[0]);

endmodule

// ==== hw/csrMerge.sv ====
`timescale 1ns/1ps

module csrMerge
   import rvviPkg::*;
#(
   parameter int NUM_CSR = 8
)(
   input  logic               rvvi,
   input  logic               arstN_i,
   input  logic               rvfiValid_i,
   input  wordT [NUM_CSR-1:0] csrWdata_i,
   input  wordT [NUM_CSR-1:0] csrRdata_i,
   input  wordT [NUM_CSR-1:0] csrWmask_i,
   output wordT [NUM_CSR-1:0] csr_o,
   output logic [NUM_CSR-1:0] csrWb_o
);

   wordT [NUM_CSR-1:0] merged;

   // Written bits from wdata, the rest from rdata
   always_comb begin
      for (int i = 0; i < NUM_CSR; i++) begin
         merged[i] = (csrWdata_i[i] & csrWmask_i[i]) | (csrRdata_i[i] & ~csrWmask_i[i]);
      end
   end

   always_ff @(posedge rvvi or negedge arstN_i) begin
      if (!arstN_i) begin
         csr_o   <= '0;
         csrWb_o <= '0;
      end else begin
         csr_o <= merged;
         for (int i = 0; i < NUM_CSR; i++) begin
            // A change wins over a retirement in the same cycle
            if (merged[i] != csr_o[i]) begin
               csrWb_o[i] <= 1'b1;
            end else if (rvfiValid_i) begin
               csrWb_o[i] <= 1'b0;
            end
         end
      end
   end

endmodule

// ==== hw/netMonitor.sv ====
`timescale 1ns/1ps

module netMonitor
   import rvviPkg::*;
(
   input  logic        rvvi,
   input  logic        arstN_i,
   input  logic        rvfiValid_i,
   input  logic [63:0] rvfiOrder_i,
   input  logic        rvfiTrap_i,
   input  logic        rvfiException_i,
   input  logic [5:0]  rvfiExcCause_i,
   input  logic        rvfiIntr_i,
   input  logic        rvfiInterrupt_i,
   input  logic [10:0] rvfiIntrCause_i,
   input  logic [1:0]  rvfiNmip_i,
   input  logic [2:0]  rvfiDbg_i,
   input  logic        rvfiDbgMode_i,
   input  logic [31:0] irq_i,
   input  logic        pushReady_i,
   output logic        push_o,
   output netSnapT     snap_o
);

   logic        seenQ;
   logic [63:0] lastOrderQ;
   logic        haltReqQ;
   logic        nmiQ;
   logic        fetchFaultQ;
   logic [10:0] nmiCauseQ;
   logic [31:0] irqQ;
   netSnapT     curSnap;
   netSnapT     lastSnapQ;
   logic        newRetire;
   logic        nmiCauseHit;
   logic        nmiHit;
   logic [10:0] nmiCauseNext;

   //////////////////////////////
   // Retirement decode
   //////////////////////////////

   assign newRetire = rvfiValid_i && (!seenQ || (rvfiOrder_i != lastOrderQ));

   assign nmiCauseHit = rvfiIntr_i && rvfiInterrupt_i &&
                        ((rvfiIntrCause_i == NMI_LOAD_CAUSE) ||
                         (rvfiIntrCause_i == NMI_STORE_CAUSE));
   assign nmiHit      = nmiCauseHit || rvfiNmip_i[0];

   // Pending NMI with no taken cause, nmip[1] tells store from load
   assign nmiCauseNext = nmiCauseHit   ? rvfiIntrCause_i :
                         rvfiNmip_i[1] ? NMI_STORE_CAUSE : NMI_LOAD_CAUSE;

   always_ff @(posedge rvvi or negedge arstN_i) begin
      if (!arstN_i) begin
         seenQ       <= 1'b0;
         lastOrderQ  <= '0;
         haltReqQ    <= 1'b0;
         nmiQ        <= 1'b0;
         fetchFaultQ <= 1'b0;
         nmiCauseQ   <= '0;
         irqQ        <= '0;
      end else begin
         irqQ <= irq_i & IRQ_USED_MASK;
         if (newRetire) begin
            seenQ       <= 1'b1;
            lastOrderQ  <= rvfiOrder_i;
            haltReqQ    <= rvfiDbgMode_i && (rvfiDbg_i == HALTREQ_DBG_CAUSE);
            nmiQ        <= nmiHit;
            fetchFaultQ <= rvfiTrap_i && rvfiException_i &&
                           (rvfiExcCause_i == FETCH_FAULT_CAUSE);
            if (nmiHit) begin
               nmiCauseQ <= nmiCauseNext;
            end
         end
      end
   end

   //////////////////////////////
   // Snapshot push
   //////////////////////////////

   always_comb begin
      curSnap            = '0;
      curSnap.irq        = irqQ;
      curSnap.nmiCause   = nmiCauseQ;
      curSnap.haltReq    = haltReqQ;
      curSnap.nmi        = nmiQ;
      curSnap.fetchFault = fetchFaultQ;
   end

   // Request stays up until the queue accepts it
   assign push_o = (curSnap != lastSnapQ);
   assign snap_o = curSnap;

   always_ff @(posedge rvvi or negedge arstN_i) begin
      if (!arstN_i) begin
         lastSnapQ <= '0;
      end else if (push_o && pushReady_i) begin
         lastSnapQ <= curSnap;
      end
   end

endmodule

// ==== hw/snapshotFifo.sv ====
`timescale 1ns/1ps

module snapshotFifo
   import rvviPkg::*;
#(
   parameter  int DEPTH = 4,
   localparam int CNT_W = $clog2(DEPTH + 1)
)(
   input  logic             rvvi,
   input  logic             arstN_i,
   input  logic             push_i,
   input  netSnapT          data_i,
   input  logic             pop_i,
   output logic             ready_o,
   output netSnapT          head_o,
   output logic             empty_o,
   output logic [CNT_W-1:0] count_o
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   netSnapT          mem [DEPTH];
   logic [PTR_W-1:0] wrPtr;
   logic [PTR_W-1:0] rdPtr;
   logic [CNT_W-1:0] count;
   logic             wrEn;
   logic             rdEn;

   // Wrap at DEPTH so any depth works
   function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign ready_o = (count != CNT_W'(DEPTH));
   assign empty_o = (count == '0);
   assign count_o = count;
   assign head_o  = mem[rdPtr];
   assign wrEn    = push_i && ready_o;
   assign rdEn    = pop_i && !empty_o;

   always_ff @(posedge rvvi) begin
      if (wrEn) begin
         mem[wrPtr] <= data_i;
      end
   end

   always_ff @(posedge rvvi or negedge arstN_i) begin
      if (!arstN_i) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (wrEn) begin
            wrPtr <= nextPtr(wrPtr);
         end
         if (rdEn) begin
            rdPtr <= nextPtr(rdPtr);
         end
         case ({wrEn, rdEn})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Occupancy never passes the depth
   countInRange: assert property (@(posedge rvvi) disable iff (!arstN_i)
      count <= CNT_W'(DEPTH));

endmodule

// ==== hw/wbEventPort.sv ====
`timescale 1ns/1ps

module wbEventPort
   import rvviPkg::*;
#(
   parameter  int DEPTH = 4,
   localparam int CNT_W = $clog2(DEPTH + 1)
)(
   input  logic             rvvi,
   input  logic             arstN_i,
   input  logic             wbCyc_i,
   input  logic             wbStb_i,
   input  logic             wbWe_i,
   input  logic [1:0]       wbAdr_i,
   input  wordT             wbDat_i,
   input  netSnapT          head_i,
   input  logic             empty_i,
   input  logic [CNT_W-1:0] count_i,
   output logic             wbAck_o,
   output wordT             wbDat_o,
   output logic             pop_o
);

   localparam logic [1:0] ADR_IRQ    = 2'd0;
   localparam logic [1:0] ADR_STATUS = 2'd1;
   localparam logic [1:0] ADR_POP    = 2'd2;

   logic    req;
   netSnapT head;
   wordT    rdData;

   // New access only while ack is low
   assign req  = wbCyc_i && wbStb_i && !wbAck_o;
   assign head = empty_i ? '0 : head_i;

   //////////////////////////////
   // Read decode
   //////////////////////////////

   // Status: cause [10:0], halt 11, nmi 12, fault 13, empty 14, count from 15
   always_comb begin
      rdData = '0;
      if (!wbWe_i) begin
         case (wbAdr_i)
            ADR_IRQ: rdData = head.irq;
            ADR_STATUS: begin
               rdData[10:0]        = head.nmiCause;
               rdData[11]          = head.haltReq;
               rdData[12]          = head.nmi;
               rdData[13]          = head.fetchFault;
               rdData[14]          = empty_i;
               rdData[15 +: CNT_W] = count_i;
            end
            default: rdData = '0;
         endcase
      end
   end

   always_ff @(posedge rvvi or negedge arstN_i) begin
      if (!arstN_i) begin
         wbAck_o <= 1'b0;
         pop_o   <= 1'b0;
      end else begin
         wbAck_o <= req;
         pop_o   <= req && wbWe_i && (wbAdr_i == ADR_POP);
      end
   end

   always_ff @(posedge rvvi) begin
      if (req) begin
         wbDat_o <= rdData;
      end
   end

   // A classic host keeps the strobe up until ack
   stbHeldToAck: assert property (@(posedge rvvi) disable iff (!arstN_i)
      req |=> (wbCyc_i && wbStb_i));

endmodule

// ==== hw/rvviBridge.sv ====
`timescale 1ns/1ps

module rvviBridge
   import rvviPkg::*;
#(
   parameter int NUM_CSR     = 8,
   parameter int EVENT_DEPTH = 4
)(
   input  logic               rvvi,
   input  logic               arstN_i,
   // Retirement port
   input  logic               rvfiValid_i,
   input  logic [63:0]        rvfiOrder_i,
   input  wordT               rvfiInsn_i,
   input  logic               rvfiTrap_i,
   input  logic               rvfiException_i,
   input  logic [5:0]         rvfiExcCause_i,
   input  logic               rvfiIntr_i,
   input  logic               rvfiInterrupt_i,
   input  logic [10:0]        rvfiIntrCause_i,
   input  logic [1:0]         rvfiNmip_i,
   input  logic [2:0]         rvfiDbg_i,
   input  logic               rvfiDbgMode_i,
   input  logic [1:0]         rvfiMode_i,
   input  logic [1:0]         rvfiIxl_i,
   input  wordT               rvfiPcRdata_i,
   input  wordT               rvfiPcWdata_i,
   input  gprMaskT            rvfiGprWmask_i,
   input  wordT [NUM_GPR-1:0] rvfiGprWdata_i,
   input  wordT [NUM_CSR-1:0] csrWdata_i,
   input  wordT [NUM_CSR-1:0] csrRdata_i,
   input  wordT [NUM_CSR-1:0] csrWmask_i,
   input  logic [31:0]        irq_i,
   // Trace side
   output logic               valid_o,
   output logic [63:0]        order_o,
   output wordT               insn_o,
   output logic               trap_o,
   output logic               intr_o,
   output logic [1:0]         mode_o,
   output logic [1:0]         ixl_o,
   output wordT               pcRdata_o,
   output wordT               pcWdata_o,
   output gprMaskT            xWb_o,
   output wordT [NUM_GPR-1:0] xWdata_o,
   output wordT [NUM_CSR-1:0] csr_o,
   output logic [NUM_CSR-1:0] csrWb_o,
   // Wishbone event port
   input  logic               wbCyc_i,
   input  logic               wbStb_i,
   input  logic               wbWe_i,
   input  logic [1:0]         wbAdr_i,
   input  wordT               wbDat_i,
   output logic               wbAck_o,
   output wordT               wbDat_o
);

   logic                               push;
   logic                               pushReady;
   logic                               pop;
   logic                               eventEmpty;
   logic [$clog2(EVENT_DEPTH+1)-1:0] eventCount;
   netSnapT                            snap;
   netSnapT                            head;

   //////////////////////////////
   // Trace path
   //////////////////////////////

   retireStage i_retireStage (
      .rvvi           (rvvi),
      .arstN_i        (arstN_i),
      .rvfiValid_i    (rvfiValid_i),
      .rvfiOrder_i    (rvfiOrder_i),
      .rvfiInsn_i     (rvfiInsn_i),
      .rvfiTrap_i     (rvfiTrap_i),
      .rvfiExcCause_i (rvfiExcCause_i),
      .rvfiIntr_i     (rvfiIntr_i),
      .rvfiMode_i     (rvfiMode_i),
      .rvfiIxl_i      (rvfiIxl_i),
      .rvfiPcRdata_i  (rvfiPcRdata_i),
      .rvfiPcWdata_i  (rvfiPcWdata_i),
      .rvfiGprWmask_i (rvfiGprWmask_i),
      .rvfiGprWdata_i (rvfiGprWdata_i),
      .valid_o        (valid_o),
      .order_o        (order_o),
      .insn_o         (insn_o),
      .trap_o         (trap_o),
      .intr_o         (intr_o),
      .mode_o         (mode_o),
      .ixl_o          (ixl_o),
      .pcRdata_o      (pcRdata_o),
      .pcWdata_o      (pcWdata_o),
      .xWb_o          (xWb_o),
      .xWdata_o       (xWdata_o)
   );

   csrMerge #(
      .NUM_CSR (NUM_CSR)
   ) i_csrMerge (
      .rvvi        (rvvi),
      .arstN_i     (arstN_i),
      .rvfiValid_i (rvfiValid_i),
      .csrWdata_i  (csrWdata_i),
      .csrRdata_i  (csrRdata_i),
      .csrWmask_i  (csrWmask_i),
      .csr_o       (csr_o),
      .csrWb_o     (csrWb_o)
   );

   //////////////////////////////
   // Net events
   //////////////////////////////

   netMonitor i_netMonitor (
      .rvvi            (rvvi),
      .arstN_i         (arstN_i),
      .rvfiValid_i     (rvfiValid_i),
      .rvfiOrder_i     (rvfiOrder_i),
      .rvfiTrap_i      (rvfiTrap_i),
      .rvfiException_i (rvfiException_i),
      .rvfiExcCause_i  (rvfiExcCause_i),
      .rvfiIntr_i      (rvfiIntr_i),
      .rvfiInterrupt_i (rvfiInterrupt_i),
      .rvfiIntrCause_i (rvfiIntrCause_i),
      .rvfiNmip_i      (rvfiNmip_i),
      .rvfiDbg_i       (rvfiDbg_i),
      .rvfiDbgMode_i   (rvfiDbgMode_i),
      .irq_i           (irq_i),
      .pushReady_i     (pushReady),
      .push_o          (push),
      .snap_o          (snap)
   );

   snapshotFifo #(
      .DEPTH (EVENT_DEPTH)
   ) i_snapshotFifo (
      .rvvi    (rvvi),
      .arstN_i (arstN_i),
      .push_i  (push),
      .data_i  (snap),
      .pop_i   (pop),
      .ready_o (pushReady),
      .head_o  (head),
      .empty_o (eventEmpty),
      .count_o (eventCount)
   );

   wbEventPort #(
      .DEPTH (EVENT_DEPTH)
   ) i_wbEventPort (
      .rvvi    (rvvi),
      .arstN_i (arstN_i),
      .wbCyc_i (wbCyc_i),
      .wbStb_i (wbStb_i),
      .wbWe_i  (wbWe_i),
      .wbAdr_i (wbAdr_i),
      .wbDat_i (wbDat_i),
      .head_i  (head),
      .empty_i (eventEmpty),
      .count_i (eventCount),
      .wbAck_o (wbAck_o),
      .wbDat_o (wbDat_o),
      .pop_o   (pop)
   );

endmodule

// ==== tb/tbClock.sv ====
`timescale 1ns/1ps

module tbClock #(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 10
)(
   output logic clk_o,
   output logic arstN_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD_NS / 2) clk_o = ~clk_o;
      end
   end

   // Reset leaves on a falling edge, clear of the sampling edge
   initial begin
      arstN_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      arstN_o = 1'b1;
   end

endmodule

// ==== tb/tbRefModel.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Only an externally raised fetch fault shows as a trap
function automatic logic refTrap(input logic trap, input logic [5:0] cause);
   return trap && (cause == 6'd48);
endfunction

// Unwritten registers and x0 read as zero
function automatic wordT refGpr(input gprMaskT mask, input wordT data, input int idx);
   if ((idx == 0) || !mask[idx]) begin
      return '0;
   end
   return data;
endfunction

function automatic wordT refCsrMerge(input wordT wdata, input wordT rdata, input wordT wmask);
   return (wdata & wmask) | (rdata & ~wmask);
endfunction

// Change raises the flag, a quiet retirement clears it
function automatic logic refCsrFlag(input logic flag, input wordT oldVal, input wordT newVal,
                                    input logic valid);
   if (newVal != oldVal) begin
      return 1'b1;
   end
   return valid ? 1'b0 : flag;
endfunction

function automatic wordT refIrq(input wordT irq);
   return irq & 32'hFFFF_0888;
endfunction

// Net state after one new retirement
function automatic netSnapT refNetUpdate(input netSnapT prev, input logic dbgMode,
                                         input logic [2:0] dbg, input logic intr,
                                         input logic interrupt, input logic [10:0] intrCause,
                                         input logic trap, input logic exception,
                                         input logic [5:0] excCause);
   netSnapT next;
   logic    nmiTaken;
   next         = prev;
   nmiTaken     = intr && interrupt && ((intrCause == 11'd1024) || (intrCause == 11'd1025));
   next.haltReq = dbgMode && (dbg == 3'd3);
   next.nmi     = nmiTaken;
   if (nmiTaken) begin
      next.nmiCause = intrCause;
   end
   next.fetchFault = trap && exception && (excCause == 6'd48);
   return next;
endfunction

// Status word as the host sees it
function automatic wordT refStatus(input netSnapT snap, input logic empty, input int count);
   wordT s;
   s       = '0;
   s[10:0] = snap.nmiCause;
   s[11]   = snap.haltReq;
   s[12]   = snap.nmi;
   s[13]   = snap.fetchFault;
   s[14]   = empty;
   s       = s | (wordT'(count) << 15);
   return s;
endfunction

`endif

// ==== tb/tbRvviBridge.sv ====
`timescale 1ns/1ps

module tbRvviBridge
   import rvviPkg::*;
();

   localparam int NUM_CSR         = 8;
   localparam int EVENT_DEPTH     = 4;
   localparam int N_RANDOM        = 200;
   localparam int STIM_CYCLES     = 10 + N_RANDOM + 4 * 30 + 6 * 3 + 6 * 12 + 20;
   localparam int WATCHDOG_CYCLES = 2 * STIM_CYCLES + 100;

   `include "tbRefModel.svh"

   logic               rvvi;
   logic               arstN;
   logic               rvfiValid;
   logic [63:0]        rvfiOrder;
   wordT               rvfiInsn;
   logic               rvfiTrap;
   logic               rvfiException;
   logic [5:0]         rvfiExcCause;
   logic               rvfiIntr;
   logic               rvfiInterrupt;
   logic [10:0]        rvfiIntrCause;
   logic [1:0]         rvfiNmip;
   logic [2:0]         rvfiDbg;
   logic               rvfiDbgMode;
   logic [1:0]         rvfiMode;
   logic [1:0]         rvfiIxl;
   wordT               rvfiPcRdata;
   wordT               rvfiPcWdata;
   gprMaskT            rvfiGprWmask;
   wordT [NUM_GPR-1:0] rvfiGprWdata;
   wordT [NUM_CSR-1:0] csrWdata;
   wordT [NUM_CSR-1:0] csrRdata;
   wordT [NUM_CSR-1:0] csrWmask;
   wordT               irqIn;
   logic               wbCyc;
   logic               wbStb;
   logic               wbWe;
   logic [1:0]         wbAdr;
   wordT               wbDatIn;
   logic               valid;
   logic [63:0]        order;
   wordT               insn;
   logic               trap;
   logic               intr;
   logic [1:0]         mode;
   logic [1:0]         ixl;
   wordT               pcRdata;
   wordT               pcWdata;
   gprMaskT            xWb;
   wordT [NUM_GPR-1:0] xWdata;
   wordT [NUM_CSR-1:0] csr;
   logic [NUM_CSR-1:0] csrWb;
   logic               wbAck;
   wordT               wbDatOut;

   // Inputs seen at the last rising edge and the expected CSR state
   logic               pValid;
   logic [63:0]        pOrder;
   wordT               pInsn;
   logic               pTrap;
   logic [5:0]         pExcCause;
   logic               pIntr;
   logic [1:0]         pMode;
   logic [1:0]         pIxl;
   wordT               pPcRdata;
   wordT               pPcWdata;
   gprMaskT            pMask;
   wordT [NUM_GPR-1:0] pGpr;
   wordT [NUM_CSR-1:0] expCsr;
   logic [NUM_CSR-1:0] expWb;
   netSnapT            expNet;
   integer             seed;

   tbClock #(.PERIOD_NS(100), .RESET_CYCLES(10)) i_tbClock (.clk_o(rvvi), .arstN_o(arstN));

   rvviBridge #(
      .NUM_CSR     (NUM_CSR),
      .EVENT_DEPTH (EVENT_DEPTH)
   ) i_rvviBridge (
      .rvvi            (rvvi),
      .arstN_i         (arstN),
      .rvfiValid_i     (rvfiValid),
      .rvfiOrder_i     (rvfiOrder),
      .rvfiInsn_i      (rvfiInsn),
      .rvfiTrap_i      (rvfiTrap),
      .rvfiException_i (rvfiException),
      .rvfiExcCause_i  (rvfiExcCause),
      .rvfiIntr_i      (rvfiIntr),
      .rvfiInterrupt_i (rvfiInterrupt),
      .rvfiIntrCause_i (rvfiIntrCause),
      .rvfiNmip_i      (rvfiNmip),
      .rvfiDbg_i       (rvfiDbg),
      .rvfiDbgMode_i   (rvfiDbgMode),
      .rvfiMode_i      (rvfiMode),
      .rvfiIxl_i       (rvfiIxl),
      .rvfiPcRdata_i   (rvfiPcRdata),
      .rvfiPcWdata_i   (rvfiPcWdata),
      .rvfiGprWmask_i  (rvfiGprWmask),
      .rvfiGprWdata_i  (rvfiGprWdata),
      .csrWdata_i      (csrWdata),
      .csrRdata_i      (csrRdata),
      .csrWmask_i      (csrWmask),
      .irq_i           (irqIn),
      .valid_o         (valid),
      .order_o         (order),
      .insn_o          (insn),
      .trap_o          (trap),
      .intr_o          (intr),
      .mode_o          (mode),
      .ixl_o           (ixl),
      .pcRdata_o       (pcRdata),
      .pcWdata_o       (pcWdata),
      .xWb_o           (xWb),
      .xWdata_o        (xWdata),
      .csr_o           (csr),
      .csrWb_o         (csrWb),
      .wbCyc_i         (wbCyc),
      .wbStb_i         (wbStb),
      .wbWe_i          (wbWe),
      .wbAdr_i         (wbAdr),
      .wbDat_i         (wbDatIn),
      .wbAck_o         (wbAck),
      .wbDat_o         (wbDatOut)
   );

   //////////////////////////////
   // Checking
   //////////////////////////////

   task automatic checkWord(input string name, input logic [63:0] got, input logic [63:0] expVal);
      assert (got === expVal) else begin
         $display("Error: %s got 0x%h expected 0x%h", name, got, expVal);
         $display("SIMULATION FAILED");
         $fatal(1, "Output mismatch");
      end
   endtask

   task automatic checkRetire();
      checkWord("valid_o", valid, pValid);
      checkWord("order_o", order, pOrder);
      checkWord("insn_o", insn, pInsn);
      checkWord("trap_o", trap, refTrap(pTrap, pExcCause));
      checkWord("intr_o", intr, pIntr);
      checkWord("mode_o", mode, pMode);
      checkWord("ixl_o", ixl, pIxl);
      checkWord("pcRdata_o", pcRdata, pPcRdata);
      checkWord("pcWdata_o", pcWdata, pPcWdata);
      checkWord("xWb_o", xWb, pMask);
      for (int i = 0; i < NUM_GPR; i++) begin
         checkWord($sformatf("xWdata_o[%0d]", i), xWdata[i], refGpr(pMask, pGpr[i], i));
      end
   endtask

   task automatic checkCsr();
      for (int i = 0; i < NUM_CSR; i++) begin
         checkWord($sformatf("csr_o[%0d]", i), csr[i], expCsr[i]);
         checkWord($sformatf("csrWb_o[%0d]", i), csrWb[i], expWb[i]);
      end
   endtask

   task automatic captureInputs();
      wordT merged;
      pValid    = rvfiValid;
      pOrder    = rvfiOrder;
      pInsn     = rvfiInsn;
      pTrap     = rvfiTrap;
      pExcCause = rvfiExcCause;
      pIntr     = rvfiIntr;
      pMode     = rvfiMode;
      pIxl      = rvfiIxl;
      pPcRdata  = rvfiPcRdata;
      pPcWdata  = rvfiPcWdata;
      pMask     = rvfiGprWmask;
      pGpr      = rvfiGprWdata;
      for (int i = 0; i < NUM_CSR; i++) begin
         merged    = refCsrMerge(csrWdata[i], csrRdata[i], csrWmask[i]);
         expWb[i]  = refCsrFlag(expWb[i], expCsr[i], merged, rvfiValid);
         expCsr[i] = merged;
      end
   endtask

   // Outputs read before the edge updates them, inputs are stable there
   initial begin : compare
      logic primed;
      primed = 1'b0;
      expCsr = '0;
      expWb  = '0;
      @(posedge arstN);
      forever begin
         @(posedge rvvi);
         if (primed) begin
            checkRetire();
         end
         checkCsr();
         captureInputs();
         primed = 1'b1;
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge rvvi);
      $display("SIMULATION FAILED");
      $fatal(1, "Watchdog expired before the tests finished");
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   function automatic wordT nextRandom();
      return $random(seed);
   endfunction

   task automatic driveIdle();
      rvfiValid     = 1'b0;
      rvfiTrap      = 1'b0;
      rvfiException = 1'b0;
      rvfiExcCause  = '0;
      rvfiIntr      = 1'b0;
      rvfiInterrupt = 1'b0;
      rvfiIntrCause = '0;
      rvfiNmip      = '0;
      rvfiDbg       = '0;
      rvfiDbgMode   = 1'b0;
   endtask

   // Trace traffic that raises no net event
   task automatic driveRandom();
      wordT r;
      @(negedge rvvi);
      r            = nextRandom();
      rvfiValid    = r[0];
      rvfiOrder    = r[0] ? rvfiOrder + 64'd1 : rvfiOrder;
      rvfiTrap     = r[1];
      rvfiExcCause = r[2] ? FETCH_FAULT_CAUSE : r[13:8];
      rvfiIntr     = r[3];
      rvfiMode     = r[5:4];
      rvfiIxl      = r[7:6];
      rvfiInsn     = nextRandom();
      rvfiPcRdata  = nextRandom();
      rvfiPcWdata  = nextRandom();
      // x0 mask bit may only rise when nothing retires
      rvfiGprWmask = nextRandom() & ~gprMaskT'(r[0]);
      for (int i = 0; i < NUM_GPR; i++) begin
         rvfiGprWdata[i] = nextRandom();
      end
      // CSRs move now and then so quiet retirements occur
      if (r[15:14] == 2'b00) begin
         for (int i = 0; i < NUM_CSR; i++) begin
            csrWdata[i] = nextRandom();
            csrRdata[i] = nextRandom();
            csrWmask[i] = nextRandom();
         end
      end
   endtask

   task automatic retireEvent(input logic haltReq, input logic nmiLoad, input logic fetchFault);
      @(negedge rvvi);
      driveIdle();
      rvfiValid    = 1'b1;
      rvfiOrder    = rvfiOrder + 64'd1;
      rvfiGprWmask = '0;
      if (haltReq) begin
         rvfiDbgMode = 1'b1;
         rvfiDbg     = 3'd3;
      end
      if (nmiLoad) begin
         rvfiIntr      = 1'b1;
         rvfiInterrupt = 1'b1;
         rvfiIntrCause = 11'd1024;
      end
      if (fetchFault) begin
         rvfiTrap      = 1'b1;
         rvfiException = 1'b1;
         rvfiExcCause  = 6'd48;
      end
      expNet = refNetUpdate(expNet, rvfiDbgMode, rvfiDbg, rvfiIntr, rvfiInterrupt,
                            rvfiIntrCause, rvfiTrap, rvfiException, rvfiExcCause);
      @(negedge rvvi);
      driveIdle();
   endtask

   // One Wishbone classic access, finished when ack is seen
   task automatic wbAccess(input logic we, input logic [1:0] adr, output wordT data);
      int waitCycles;
      @(negedge rvvi);
      wbCyc      = 1'b1;
      wbStb      = 1'b1;
      wbWe       = we;
      wbAdr      = adr;
      wbDatIn    = '0;
      waitCycles = 0;
      do begin
         @(posedge rvvi);
         waitCycles++;
      end while ((wbAck !== 1'b1) && (waitCycles < 8));
      if (wbAck !== 1'b1) begin
         $display("SIMULATION FAILED");
         $fatal(1, "Wishbone slave never acknowledged the access");
      end else begin
         data = wbDatOut;
         @(negedge rvvi);
         wbCyc = 1'b0;
         wbStb = 1'b0;
         wbWe  = 1'b0;
      end
   endtask

   // A negative count skips the count field
   task automatic expectHead(input netSnapT expSnap, input int expCount);
      wordT rd;
      int   tries;
      tries = 0;
      do begin
         wbAccess(1'b0, 2'd1, rd);
         tries++;
      end while (rd[14] && (tries < 6));
      if (rd[14]) begin
         $display("SIMULATION FAILED");
         $fatal(1, "Expected net event never reached the queue");
      end else begin
         wbAccess(1'b0, 2'd0, rd);
         checkWord("wbDat_o irq", rd, expSnap.irq);
         wbAccess(1'b0, 2'd1, rd);
         if (expCount >= 0) begin
            checkWord("wbDat_o status", rd, refStatus(expSnap, 1'b0, expCount));
         end else begin
            checkWord("wbDat_o status", rd & 32'h7FFF, refStatus(expSnap, 1'b0, 0) & 32'h7FFF);
         end
      end
   endtask

   task automatic popHead();
      wordT rd;
      wbAccess(1'b1, 2'd2, rd);
   endtask

   task automatic checkDrained();
      wordT rd;
      wbAccess(1'b0, 2'd1, rd);
      checkWord("wbDat_o empty flag", rd[14], 1'b1);
      checkWord("wbDat_o count", rd >> 15, 0);
   endtask

   initial begin : stimulus
      wordT    irqHist [6];
      wordT    nextIrq;
      wordT    rd;
      netSnapT expHead;
      seed         = 32'ha6bc;
      expNet       = '0;
      driveIdle();
      rvfiOrder    = '0;
      rvfiInsn     = '0;
      rvfiMode     = '0;
      rvfiIxl      = '0;
      rvfiPcRdata  = '0;
      rvfiPcWdata  = '0;
      rvfiGprWmask = '0;
      rvfiGprWdata = '0;
      csrWdata     = '0;
      csrRdata     = '0;
      csrWmask     = '0;
      irqIn        = '0;
      wbCyc        = 1'b0;
      wbStb        = 1'b0;
      wbWe         = 1'b0;
      wbAdr        = '0;
      wbDatIn      = '0;
      @(posedge arstN);

      // Retirement record, GPR masking and CSR merge
      repeat (N_RANDOM) driveRandom();
      @(negedge rvvi);
      driveIdle();
      checkDrained();

      // Net events, one at a time
      retireEvent(1'b1, 1'b0, 1'b0);
      expectHead(expNet, 1);
      popHead();
      retireEvent(1'b0, 1'b1, 1'b0);
      expectHead(expNet, 1);
      popHead();
      retireEvent(1'b0, 1'b0, 1'b1);
      expectHead(expNet, 1);
      popHead();
      retireEvent(1'b0, 1'b0, 1'b0);
      expectHead(expNet, 1);
      popHead();
      checkDrained();

      // Six irq changes with no reads, the queue fills
      for (int k = 0; k < 6; k++) begin
         @(negedge rvvi);
         nextIrq = nextRandom() | 32'h0000_0004;
         if ((refIrq(nextIrq) == refIrq(irqIn))) begin
            nextIrq = nextIrq ^ 32'h0001_0000;
         end
         irqIn      = nextIrq;
         irqHist[k] = refIrq(nextIrq);
         repeat (2) @(negedge rvvi);
      end
      expHead     = expNet;
      expHead.irq = irqHist[0];
      wbAccess(1'b0, 2'd1, rd);
      checkWord("wbDat_o status", rd, refStatus(expHead, 1'b0, EVENT_DEPTH));

      // Oldest four first, then the merged latest state
      for (int k = 0; k < 5; k++) begin
         expHead     = expNet;
         expHead.irq = (k < 4) ? irqHist[k] : irqHist[5];
         expectHead(expHead, -1);
         popHead();
      end
      checkDrained();

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+tb
hw/rvviPkg.sv
hw/retireStage.sv
hw/csrMerge.sv
hw/netMonitor.sv
hw/snapshotFifo.sv
hw/wbEventPort.sv
hw/rvviBridge.sv
tb/tbClock.sv
tb/tbRvviBridge.sv

// ==== Makefile ====
# Verilator build and run of the RVFI to RVVI bridge testbench

VERILATOR := verilator
TOP       := tbRvviBridge
FILELIST  := verilog.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal -Mdir $(OBJDIR) --top-module $(TOP)

SOURCES   := $(wildcard hw/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)
BIN       := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# A $fatal in the testbench gives a failing exit status
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)
